// File: Bender.yml
package:
  name: alu_unit

sources:
  - files:
      - verilog/aluPkg.sv
      - verilog/aluStageIf.sv
      - verilog/aluDecode.sv
      - verilog/aluExecute.sv
      - verilog/aluResult.sv
      - verilog/aluUnit.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/aluUnitTb.sv

// File: bench/aluModel.svh
/*
 Reference model for the ALU testbench. Works out the expected value and
 the new T and S of one operation from the opcode rules, lane by lane.
 Included inside the testbench module after the aluPkg import.
*/
`ifndef ALU_MODEL_SVH
`define ALU_MODEL_SVH

// one lane of w bits; flagIn is the carry/borrow in, the select bit or the kept flag
function automatic logic [64:0] laneCalc(input logic [3:0] op, input logic [63:0] a,
		input logic [63:0] b, input int w, input logic flagIn);
	logic [63:0] mask;
	logic [63:0] x;
	logic [63:0] y;
	logic [64:0] wide;
	logic [63:0] r;
	logic f;
	logic below;
	logic belowSigned;
	mask = (w == 64) ? {64{1'b1}} : 64'h0000_0000_FFFF_FFFF;
	x = a & mask;
	y = b & mask;
	below = x < y;
	// signs differ, so the negative one is smaller
	belowSigned = (x[w-1] != y[w-1]) ? x[w-1] : below;
	r = '0;
	f = flagIn;
	case (op)
		opAdd: r = x + y;
		opSub: r = x - y;
		opAdc: begin
			wide = {1'b0, x} + {1'b0, y} + flagIn;
			r = wide[63:0];
			f = wide[w];
		end
		opSbb: begin
			// a negative difference means a borrow out
			wide = {1'b0, x} - {1'b0, y} - flagIn;
			r = wide[63:0];
			f = wide[64];
		end
		opAnd: r = x & y;
		opOr: r = x | y;
		opXor: r = x ^ y;
		opNor: r = ~(x | y);
		opCselt: r = flagIn ? x : y;
		opTst: f = (x & y) == 64'h0;
		opCmpEq: f = x == y;
		opCmpNe: f = x != y;
		opCmpHs: f = !below;
		opCmpHi: f = !below && (x != y);
		opCmpGe: f = !belowSigned;
		opCmpGt: f = !belowSigned && (x != y);
		default: f = flagIn;
	endcase
	return {f, r & mask};
endfunction

// returns {S, T, value} after the operation
function automatic logic [65:0] modelOp(input logic [7:0] x, input logic [63:0] rs,
		input logic [63:0] rt, input logic t, input logic s);
	logic [64:0] lo;
	logic [64:0] hi;
	if (x[5] && x[4]) begin
		lo = laneCalc(x[3:0], rs[31:0], rt[31:0], 32, t);
		hi = laneCalc(x[3:0], rs[63:32], rt[63:32], 32, s);
		return {hi[64], lo[64], hi[31:0], lo[31:0]};
	end else if (x[5]) begin
		lo = laneCalc(x[3:0], rs, rt, 64, t);
		return {s, lo[64], lo[63:0]};
	end
	lo = laneCalc(x[3:0], rs, rt, 32, t);
	if (x[4])
		return {s, lo[64], 32'h0, lo[31:0]};
	return {s, lo[64], {32{lo[31]}}, lo[31:0]};
endfunction

function automatic logic condPasses(input logic [1:0] cc, input logic t);
	case (cc)
		2'b00: return 1'b1;
		2'b10: return t;
		2'b11: return !t;
		default: return 1'b0;
	endcase
endfunction

// TST and the compares only touch status
function automatic logic opWritesValue(input logic [3:0] op);
	return !(op == opTst || op == opCmpNe || op == opCmpHs || op == opCmpGe
		|| op == opCmpEq || op == opCmpHi || op == opCmpGt);
endfunction

`endif

// File: bench/aluUnitTb.sv
/*
 Directed testbench for the ALU slice top level. Each test task issues
 operations, queues the model's expected response and checks done,
 valueValid, value, T and S when the result stage reports it.
*/
`timescale 1ns/10ps
`default_nettype none

module aluUnitTb;
	import aluPkg::*;
	`include "aluModel.svh"

	localparam int clockPeriod = 10;
	// rough cycles per test, in run order, plus slack
	localparam int plannedCycles = 10 + 100 + 35 + 95 + 20 + 25 + 25;
	localparam int marginCycles = 100;

	logic clock;
	logic rstN;
	logic issue;
	logic [7:0] ixt;
	logic [63:0] valRs;
	logic [63:0] valRt;
	logic hold;
	logic srLoad;
	logic [1:0] srLoadVal;
	logic done;
	logic valueValid;
	logic [63:0] value;
	logic srT;
	logic srS;

	int errorCount = 0;
	int edgeCount = 0;
	logic modelT = 1'b0;
	logic modelS = 1'b0;
	logic [31:0] lcgState = 32'h2dd9_7e3d;
	// expected {done, valueValid, T, S, value} and the edge it is due at
	logic [67:0] expQ[$];
	int dueQ[$];

	aluUnit #(
		.enablePacked(1'b1)
	) UUT (
		.clock(clock),
		.rstN(rstN),
		.issue(issue),
		.ixt(ixt),
		.valRs(valRs),
		.valRt(valRt),
		.hold(hold),
		.srLoad(srLoad),
		.srLoadVal(srLoadVal),
		.done(done),
		.valueValid(valueValid),
		.value(value),
		.srT(srT),
		.srS(srS)
	);

	always #(clockPeriod / 2) clock = ~clock;

	initial begin
		#((plannedCycles + marginCycles) * clockPeriod);
		$display("watchdog expired, the tests did not finish in time");
		$display("TESTS FAILED");
		$finish;
	end

	function automatic logic [31:0] lcgNext();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	function automatic logic [63:0] randWord();
		logic [63:0] w;
		w[63:32] = lcgNext();
		w[31:0] = lcgNext();
		return w;
	endfunction

	task automatic checkValue(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		if (actual !== expected) begin
			errorCount++;
			$display("ERROR at %0t: %s expected %h, got %h", $time, name, expected, actual);
		end
	endtask

	// one clock, then check whatever result is due at this edge
	task automatic step();
		logic [67:0] e;
		logic held;
		@(posedge clock);
		held = hold;
		#1;
		if (!held)
			edgeCount++;
		if (!held && dueQ.size() > 0 && dueQ[0] == edgeCount) begin
			e = expQ.pop_front();
			void'(dueQ.pop_front());
			checkValue("done", e[67], done);
			checkValue("valueValid", e[66], valueValid);
			checkValue("srT", e[65], srT);
			checkValue("srS", e[64], srS);
			if (e[66])
				checkValue("value", e[63:0], value);
		end else begin
			checkValue("done", 1'b0, done);
			checkValue("valueValid", 1'b0, valueValid);
		end
	endtask

	task automatic drain();
		while (dueQ.size() != 0)
			step();
	endtask

	task automatic issueOp(input logic [7:0] x, input logic [63:0] a, input logic [63:0] b);
		logic [65:0] m;
		logic go;
		go = condPasses(x[7:6], modelT);
		m = modelOp(x, a, b, modelT, modelS);
		if (go) begin
			modelT = m[64];
			modelS = m[65];
		end
		expQ.push_back({go, go && opWritesValue(x[3:0]), modelT, modelS, m[63:0]});
		dueQ.push_back(edgeCount + 2);
		issue = 1'b1;
		ixt = x;
		valRs = a;
		valRt = b;
		step();
		issue = 1'b0;
	endtask

	// bit 0 presets T, bit 1 presets S
	task automatic loadStatus(input logic [1:0] val);
		drain();
		srLoad = 1'b1;
		srLoadVal = val;
		step();
		srLoad = 1'b0;
		modelT = val[0];
		modelS = val[1];
	endtask

	task automatic arithLogicOps();
		logic [27:0] opList;
		opList = {opAdd, opSub, opAnd, opOr, opXor, opNor, opCselt};
		for (int k = 0; k < 2; k++) begin
			// CSELT sees T both ways, S must survive
			loadStatus(k == 0 ? 2'b10 : 2'b01);
			for (int m = 0; m < 3; m++)
				for (int i = 0; i < 7; i++)
					for (int n = 0; n < 2; n++)
						issueOp({ccAlways, m[1:0], opList[4*i +: 4]}, randWord(), randWord());
			drain();
		end
	endtask

	task automatic carryChains();
		loadStatus(2'b01);
		// carry in crosses the first 16-bit lane
		issueOp({ccAlways, 2'b00, opAdc}, 64'h0000_0000_0000_FFFF, 64'h0);
		issueOp({ccAlways, 2'b00, opAdc}, 64'h0000_0000_FFFF_FFFF, 64'h1);
		issueOp({ccAlways, 2'b10, opAdc}, 64'h0000_0000_FFFF_FFFF, 64'h0);
		issueOp({ccAlways, 2'b10, opAdc}, 64'hFFFF_FFFF_FFFF_FFFF, 64'h1);
		issueOp({ccAlways, 2'b10, opAdc}, 64'h0, 64'h0);
		for (int i = 0; i < 6; i++)
			issueOp({ccAlways, 1'b1, 1'b0, opAdc}, randWord(), randWord());
		loadStatus(2'b01);
		// borrow in ripples across the 32-bit boundary
		issueOp({ccAlways, 2'b10, opSbb}, 64'h0000_0001_0000_0000, 64'h0);
		issueOp({ccAlways, 2'b00, opSbb}, 64'h0, 64'h1);
		issueOp({ccAlways, 2'b00, opSbb}, 64'h0000_0000_0001_0000, 64'h0);
		for (int i = 0; i < 6; i++)
			issueOp({ccAlways, i[0], 1'b0, opSbb}, randWord(), randWord());
		drain();
	endtask

	task automatic compareOps();
		logic [27:0] opList;
		logic [63:0] a;
		logic [63:0] b;
		opList = {opTst, opCmpNe, opCmpHs, opCmpGe, opCmpEq, opCmpHi, opCmpGt};
		for (int p = 0; p < 6; p++) begin
			a = randWord();
			b = randWord();
			case (p)
				1: b = a;
				2: begin
					a = 64'h8000_0000_8000_0000;
					b = 64'h7FFF_FFFF_7FFF_FFFF;
				end
				3: begin
					a = 64'h7FFF_FFFF_7FFF_FFFF;
					b = 64'h8000_0000_8000_0000;
				end
				4: begin
					a = '1;
					b = 64'h0;
				end
				5: begin
					a = '1;
					b = '1;
				end
				default: ;
			endcase
			for (int m = 0; m < 2; m++)
				for (int i = 0; i < 7; i++)
					issueOp({ccAlways, m[0], 1'b0, opList[4*i +: 4]}, a, b);
		end
		drain();
	endtask

	task automatic conditionCodes();
		loadStatus(2'b00);
		// equal operands would set T if these ran
		issueOp({ccNever, 2'b10, opCmpEq}, 64'h5, 64'h5);
		issueOp({ccIfT, 2'b10, opCmpEq}, 64'h5, 64'h5);
		issueOp({ccAlways, 2'b10, opAdd}, randWord(), randWord());
		issueOp({ccIfNotT, 2'b00, opAdd}, randWord(), randWord());
		issueOp({ccAlways, 2'b10, opCmpEq}, 64'h7, 64'h7);
		issueOp({ccIfT, 2'b00, opSub}, randWord(), randWord());
		issueOp({ccIfNotT, 2'b00, opSub}, randWord(), randWord());
		drain();
	endtask

	task automatic packedLanes();
		logic [27:0] opList;
		opList = {opAdd, opSub, opAdc, 16'h0};
		loadStatus(2'b00);
		// neither carry nor borrow may cross into the high lane
		issueOp({ccAlways, 2'b11, opAdd}, 64'h0000_0000_FFFF_FFFF, 64'h1);
		issueOp({ccAlways, 2'b11, opSub}, 64'h0000_0001_0000_0000, 64'h1);
		loadStatus(2'b01);
		issueOp({ccAlways, 2'b11, opAdc}, 64'hFFFF_FFFF_FFFF_FFFF, 64'h0);
		issueOp({ccAlways, 2'b11, opAdc}, 64'hFFFF_FFFF_0000_0000, 64'h0000_0001_0000_0000);
		issueOp({ccAlways, 2'b11, opAdc}, 64'h0, 64'h0);
		for (int i = 0; i < 9; i++)
			issueOp({ccAlways, 2'b11, opList[4*(6-(i%3)) +: 4]}, randWord(), randWord());
		drain();
	endtask

	task automatic holdAndReset();
		loadStatus(2'b11);
		issueOp({ccAlways, 2'b10, opAdc}, randWord(), randWord());
		// stall with the operation in the result stage's input
		hold = 1'b1;
		repeat (3) step();
		hold = 1'b0;
		drain();
		// both status bits set so reset has something to clear
		loadStatus(2'b11);
		issueOp({ccAlways, 2'b10, opAdc}, randWord(), randWord());
		rstN = 1'b0;
		expQ.delete();
		dueQ.delete();
		repeat (5) step();
		checkValue("srT", 1'b0, srT);
		checkValue("srS", 1'b0, srS);
		rstN = 1'b1;
		modelT = 1'b0;
		modelS = 1'b0;
		issueOp({ccAlways, 2'b00, opAdd}, randWord(), randWord());
		drain();
	endtask

	initial begin
		clock = 1'b0;
		rstN = 1'b0;
		issue = 1'b0;
		ixt = 8'h0;
		valRs = 64'h0;
		valRt = 64'h0;
		hold = 1'b0;
		srLoad = 1'b0;
		srLoadVal = 2'b00;
		repeat (5) @(posedge clock);
		#1;
		rstN = 1'b1;
		arithLogicOps();
		carryChains();
		compareOps();
		conditionCodes();
		packedLanes();
		holdAndReset();
		$display("ALU slice tests done with %0d errors", errorCount);
		if (errorCount == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: sources.f
+incdir+bench
verilog/aluPkg.sv
verilog/aluStageIf.sv
verilog/aluDecode.sv
verilog/aluExecute.sv
verilog/aluResult.sv
verilog/aluUnit.sv
bench/aluUnitTb.sv

// File: verilog/aluDecode.sv
/*
 Decode stage of the ALU slice. Registers an issued operation with its
 operands and splits the extension word into opcode, condition and width
 flags. Everything holds while hold is high.
*/
`timescale 1ns/10ps
`default_nettype none

module aluDecode #(
	parameter bit enablePacked = 1'b1
) (
	input wire logic clock,
	input wire logic rstN,
	input wire logic issue,
	input wire aluPkg::uIxt ixt,
	input wire aluPkg::word64 valRs,
	input wire aluPkg::word64 valRt,
	input wire logic hold,
	decodedOpIf.source dec
);
	import aluPkg::*;

	aluOp fieldOp;
	condCode fieldCc;
	logic fieldQWord;
	logic fieldZExt;
	logic fieldPacked;
	logic capture;

	// extension word fields
	assign fieldOp = aluOp'(ixt[ixtOpMsb:ixtOpLsb]);
	assign fieldCc = condCode'(ixt[ixtCcMsb:ixtCcLsb]);
	assign fieldQWord = ixt[ixtQWordBit];
	assign fieldZExt = ixt[ixtZExtBit];

	// Q+ZX selects dual-DWord only when the packed lanes are built in,
	// otherwise it falls back to a plain 64-bit operation
	assign fieldPacked = enablePacked && fieldQWord && fieldZExt;

	assign capture = issue && !hold;

	always_ff @(posedge clock) begin
		if (!rstN) begin
			dec.valid <= 1'b0;
		end else if (!hold) begin
			dec.valid <= issue;
		end
	end

	always_ff @(posedge clock) begin
		if (capture) begin
			dec.op <= fieldOp;
			dec.cc <= fieldCc;
			dec.qword <= fieldQWord;
			dec.zext <= fieldZExt;
			dec.packedOp <= fieldPacked;
			dec.rs <= valRs;
			dec.rt <= valRt;
		end
	end

endmodule

`default_nettype wire

// File: verilog/aluExecute.sv
/*
 Execute stage of the ALU slice, purely combinational. Builds carry-select
 add and subtract chains from 16-bit lanes, the logic values and the
 compare flags, and hands per-width result candidates to the result stage.
*/
`timescale 1ns/10ps
`default_nettype none

module aluExecute (
	decodedOpIf.sink dec,
	input wire logic srT,
	input wire logic srS,
	aluResultIf.source res
);
	import aluPkg::*;

	// 16-bit lane sums for carry in 0 and 1
	logic [16:0] addLane0 [4];
	logic [16:0] addLane1 [4];
	logic [16:0] subLane0 [4];
	logic [16:0] subLane1 [4];

	sum33 addLo0, addLo1, addHi0, addHi1;
	sum33 subLo0, subLo1, subHi0, subHi1;
	sum65 addFull0, addFull1, subFull0, subFull1;

	word64 andVal, orVal, xorVal, norVal, cselVal;
	word32 cselHi;

	logic zero32, zero64, zeroHi;
	logic tst32, tst64, tstHi;

	sum33 lowSum, highSum;
	sum65 fullSum;

	// upper lane picked by the carry of the lower one
	function automatic sum33 joinLanes(logic [16:0] lo, logic [16:0] hi0, logic [16:0] hi1);
		return {lo[16] ? hi1 : hi0, lo[15:0]};
	endfunction

	function automatic sum65 joinWords(sum33 lo, sum33 hi0, sum33 hi1);
		return {lo[32] ? hi1 : hi0, lo[31:0]};
	endfunction

	// status candidate for one width; keep is the bit left untouched
	function automatic logic pickFlag(
		aluOp op,
		logic keep,
		logic cout,
		logic tstZero,
		logic zero,
		logic carry,
		logic rsSign,
		logic rtSign,
		logic diffSign
	);
		logic ge;
		// signs differ: Rs is above only when Rt is negative
		ge = (rsSign != rtSign) ? rtSign : !diffSign;
		case (op)
			opAdc: return cout;
			opSbb: return !cout;
			opTst: return tstZero;
			opCmpNe: return !zero;
			opCmpEq: return zero;
			opCmpHs: return carry;
			opCmpHi: return carry && !zero;
			opCmpGe: return ge;
			opCmpGt: return ge && !zero;
			default: return keep;
		endcase
	endfunction

	always_comb begin
		for (int i = 0; i < 4; i++) begin
			addLane0[i] = {1'b0, dec.rs[16*i +: 16]} + {1'b0, dec.rt[16*i +: 16]};
			addLane1[i] = {1'b0, dec.rs[16*i +: 16]} + {1'b0, dec.rt[16*i +: 16]} + 17'd1;
			subLane0[i] = {1'b0, dec.rs[16*i +: 16]} + {1'b0, ~dec.rt[16*i +: 16]};
			subLane1[i] = {1'b0, dec.rs[16*i +: 16]} + {1'b0, ~dec.rt[16*i +: 16]} + 17'd1;
		end
	end

	assign addLo0 = joinLanes(addLane0[0], addLane0[1], addLane1[1]);
	assign addLo1 = joinLanes(addLane1[0], addLane0[1], addLane1[1]);
	assign addHi0 = joinLanes(addLane0[2], addLane0[3], addLane1[3]);
	assign addHi1 = joinLanes(addLane1[2], addLane0[3], addLane1[3]);
	assign subLo0 = joinLanes(subLane0[0], subLane0[1], subLane1[1]);
	assign subLo1 = joinLanes(subLane1[0], subLane0[1], subLane1[1]);
	assign subHi0 = joinLanes(subLane0[2], subLane0[3], subLane1[3]);
	assign subHi1 = joinLanes(subLane1[2], subLane0[3], subLane1[3]);

	assign addFull0 = joinWords(addLo0, addHi0, addHi1);
	assign addFull1 = joinWords(addLo1, addHi0, addHi1);
	assign subFull0 = joinWords(subLo0, subHi0, subHi1);
	assign subFull1 = joinWords(subLo1, subHi0, subHi1);

	assign andVal = dec.rs & dec.rt;
	assign orVal = dec.rs | dec.rt;
	assign xorVal = dec.rs ^ dec.rt;
	assign norVal = ~(dec.rs | dec.rt);
	assign cselVal = srT ? dec.rs : dec.rt;
	// packed high lane selects on S
	assign cselHi = srS ? dec.rs[63:32] : dec.rt[63:32];

	// zero flags of Rs - Rt and of Rs & Rt
	assign zero32 = subLo1[31:0] == '0;
	assign zeroHi = subHi1[31:0] == '0;
	assign zero64 = subFull1[63:0] == '0;
	assign tst32 = andVal[31:0] == '0;
	assign tstHi = andVal[63:32] == '0;
	assign tst64 = andVal == '0;

	always_comb begin
		lowSum = '0;
		highSum = '0;
		fullSum = '0;
		res.writesValue = 1'b1;
		case (dec.op)
			opAdd: begin
				lowSum = addLo0;
				highSum = addHi0;
				fullSum = addFull0;
			end
			opSub: begin
				lowSum = subLo1;
				highSum = subHi1;
				fullSum = subFull1;
			end
			opAdc: begin
				lowSum = srT ? addLo1 : addLo0;
				highSum = srS ? addHi1 : addHi0;
				fullSum = srT ? addFull1 : addFull0;
			end
			opSbb: begin
				// borrow in set means no extra +1
				lowSum = srT ? subLo0 : subLo1;
				highSum = srS ? subHi0 : subHi1;
				fullSum = srT ? subFull0 : subFull1;
			end
			opAnd: begin
				lowSum = {1'b0, andVal[31:0]};
				highSum = {1'b0, andVal[63:32]};
				fullSum = {1'b0, andVal};
			end
			opOr: begin
				lowSum = {1'b0, orVal[31:0]};
				highSum = {1'b0, orVal[63:32]};
				fullSum = {1'b0, orVal};
			end
			opXor: begin
				lowSum = {1'b0, xorVal[31:0]};
				highSum = {1'b0, xorVal[63:32]};
				fullSum = {1'b0, xorVal};
			end
			opNor: begin
				lowSum = {1'b0, norVal[31:0]};
				highSum = {1'b0, norVal[63:32]};
				fullSum = {1'b0, norVal};
			end
			opCselt: begin
				lowSum = {1'b0, cselVal[31:0]};
				highSum = {1'b0, cselHi};
				fullSum = {1'b0, cselVal};
			end
			default: begin
				// TST and compares only touch status
				res.writesValue = 1'b0;
			end
		endcase
	end

	assign res.lowLane = lowSum;
	assign res.highLane = highSum;
	assign res.full = fullSum;

	assign res.t32 = pickFlag(dec.op, srT, lowSum[32], tst32, zero32, subLo1[32],
		dec.rs[31], dec.rt[31], subLo1[31]);
	assign res.t64 = pickFlag(dec.op, srT, fullSum[64], tst64, zero64, subFull1[64],
		dec.rs[63], dec.rt[63], subFull1[63]);
	assign res.s32 = pickFlag(dec.op, srS, highSum[32], tstHi, zeroHi, subHi1[32],
		dec.rs[63], dec.rt[63], subHi1[31]);

endmodule

`default_nettype wire

// File: verilog/aluPkg.sv
/*
 Shared types for the integer ALU slice: opcode and condition encodings,
 operand and sum widths, and the bit positions inside the extension word.
 Imported by the decode, execute and result stages and their interfaces.
*/
`default_nettype none

package aluPkg;

	// opcode field of the extension word, bits 3..0
	typedef enum logic [3:0] {
		opAdd = 4'h0,
		opSub = 4'h1,
		opAdc = 4'h2,
		opSbb = 4'h3,
		opTst = 4'h4,
		opAnd = 4'h5,
		opOr = 4'h6,
		opXor = 4'h7,
		opCmpNe = 4'h8,
		opCmpHs = 4'h9,
		opCmpGe = 4'hA,
		opNor = 4'hB,
		opCmpEq = 4'hC,
		opCmpHi = 4'hD,
		opCmpGt = 4'hE,
		opCselt = 4'hF
	} aluOp;

	// condition code, bits 7..6
	typedef enum logic [1:0] {
		ccAlways = 2'b00,
		ccNever = 2'b01,
		ccIfT = 2'b10,
		ccIfNotT = 2'b11
	} condCode;

	typedef logic [63:0] word64;
	typedef logic [31:0] word32;

	// lane and full sums, carry out in the top bit
	typedef logic [32:0] sum33;
	typedef logic [64:0] sum65;

	typedef logic [7:0] uIxt;

	// extension word layout
	localparam int unsigned ixtCcMsb = 7;
	localparam int unsigned ixtCcLsb = 6;
	localparam int unsigned ixtQWordBit = 5;
	localparam int unsigned ixtZExtBit = 4;
	localparam int unsigned ixtOpMsb = 3;
	localparam int unsigned ixtOpLsb = 0;

endpackage

`default_nettype wire

// File: verilog/aluResult.sv
/*
 Result stage of the ALU slice. Checks the condition code, selects and
 extends the output width, and registers the value, the done pulses and
 the T/S status register. The status can be preset through srLoad.
*/
`timescale 1ns/10ps
`default_nettype none

module aluResult (
	input wire logic clock,
	input wire logic rstN,
	input wire logic hold,
	decodedOpIf.sink dec,
	aluResultIf.sink res,
	input wire logic srLoad,
	input wire logic [1:0] srLoadVal,
	output logic done,
	output logic valueValid,
	output aluPkg::word64 value,
	output logic srT,
	output logic srS
);
	import aluPkg::*;

	logic condOk;
	logic complete;
	word64 nextValue;
	logic nextT;
	logic nextS;

	always_comb begin
		case (dec.cc)
			ccAlways: condOk = 1'b1;
			ccIfT: condOk = srT;
			ccIfNotT: condOk = !srT;
			default: condOk = 1'b0;
		endcase
	end

	assign complete = dec.valid && condOk;

	// width selection
	always_comb begin
		if (dec.packedOp) begin
			nextValue = {res.highLane[31:0], res.lowLane[31:0]};
			nextT = res.t32;
			nextS = res.s32;
		end else if (dec.qword) begin
			nextValue = res.full[63:0];
			nextT = res.t64;
			nextS = srS;
		end else begin
			if (dec.zext)
				nextValue = {32'h0, res.lowLane[31:0]};
			else
				nextValue = {{32{res.lowLane[31]}}, res.lowLane[31:0]};
			nextT = res.t32;
			nextS = srS;
		end
	end

	always_ff @(posedge clock) begin
		if (!rstN) begin
			done <= 1'b0;
			valueValid <= 1'b0;
			srT <= 1'b0;
			srS <= 1'b0;
		end else if (hold) begin
			// no pulses while stalled
			done <= 1'b0;
			valueValid <= 1'b0;
		end else begin
			done <= complete;
			valueValid <= complete && res.writesValue;
			if (complete) begin
				srT <= nextT;
				srS <= nextS;
			end else if (srLoad) begin
				srT <= srLoadVal[0];
				srS <= srLoadVal[1];
			end
		end
	end

	always_ff @(posedge clock) begin
		if (!hold && complete && res.writesValue)
			value <= nextValue;
	end

endmodule

`default_nettype wire

// File: verilog/aluStageIf.sv
/*
 Stage-to-stage bundles of the ALU slice. decodedOpIf carries the
 registered operation from decode; aluResultIf carries the result
 candidates and flags from execute into the result stage.
*/
`timescale 1ns/10ps
`default_nettype none

interface decodedOpIf;
	import aluPkg::*;

	logic valid;
	aluOp op;
	logic qword;
	logic zext;
	// both DWord lanes used independently
	logic packedOp;
	condCode cc;
	word64 rs;
	word64 rt;

	modport source (
		output valid, op, qword, zext, packedOp, cc,
		output rs, rt
	);

	modport sink (
		input valid, op, qword, zext, packedOp, cc,
		input rs, rt
	);
endinterface

interface aluResultIf;
	import aluPkg::*;

	sum33 lowLane;
	sum33 highLane;
	sum65 full;
	// status candidates for 32-bit, 64-bit and high lane
	logic t32;
	logic t64;
	logic s32;
	logic writesValue;

	modport source (
		output lowLane, highLane, full,
		output t32, t64, s32, writesValue
	);

	modport sink (
		input lowLane, highLane, full,
		input t32, t64, s32, writesValue
	);
endinterface

`default_nettype wire

// File: verilog/aluUnit.sv
/*
 Top level of the integer ALU slice. Connects the decode, execute and
 result stages; an issued operation completes two edges later.
 enablePacked turns the dual-DWord lane mode on or off.
*/
`timescale 1ns/10ps
`default_nettype none

module aluUnit #(
	parameter bit enablePacked = 1'b1
) (
	input wire logic clock,
	input wire logic rstN,
	input wire logic issue,
	input wire aluPkg::uIxt ixt,
	input wire aluPkg::word64 valRs,
	input wire aluPkg::word64 valRt,
	input wire logic hold,
	input wire logic srLoad,
	input wire logic [1:0] srLoadVal,
	output logic done,
	output logic valueValid,
	output aluPkg::word64 value,
	output logic srT,
	output logic srS
);

	decodedOpIf decIf ();
	aluResultIf resIf ();

	aluDecode #(
		.enablePacked(enablePacked)
	) decodeStage (
		.clock(clock),
		.rstN(rstN),
		.issue(issue),
		.ixt(ixt),
		.valRs(valRs),
		.valRt(valRt),
		.hold(hold),
		.dec(decIf.source)
	);

	// status feeds back for ADC, SBB and CSELT
	aluExecute executeStage (
		.dec(decIf.sink),
		.srT(srT),
		.srS(srS),
		.res(resIf.source)
	);

	aluResult resultStage (
		.clock(clock),
		.rstN(rstN),
		.hold(hold),
		.dec(decIf.sink),
		.res(resIf.sink),
		.srLoad(srLoad),
		.srLoadVal(srLoadVal),
		.done(done),
		.valueValid(valueValid),
		.value(value),
		.srT(srT),
		.srS(srS)
	);

endmodule

`default_nettype wire
